//--- all.f
+incdir+include
source/radio_regs_pkg.sv
source/frontend_io_pkg.sv
source/setting_reg.sv
source/gpio_atr.sv
source/simple_spi_core.sv
source/db_control.sv
tests/tb_clk_gen.sv
tests/db_control_assert.sv
tests/db_control_tb.sv

//--- include/db_control_cfg.svh
// Register map, readback codes, reset defaults and bus widths
// for the daughterboard control block
`ifndef DB_CONTROL_CFG_SVH
`define DB_CONTROL_CFG_SVH

// Bus and field widths
`define SR_AWIDTH         8
`define SR_DWIDTH         32
`define RB_AWIDTH         8
`define RB_DWIDTH         64
`define GPIO_WIDTH        32
`define SEN_WIDTH         8
`define SPI_DIV_WIDTH     16

// Settings addresses, GPIO banks take five words each, SPI takes three
`define SR_MISC_OUTS      8'h10
`define SR_SYNC           8'h11
`define SR_SPI            8'h18
`define SR_LEDS           8'h20
`define SR_FP_GPIO        8'h28
`define SR_DB_GPIO        8'h30

// Readback select codes
`define RB_MISC_IO        8'd0
`define RB_SPI            8'd1
`define RB_LEDS           8'd2
`define RB_DB_GPIO        8'd3
`define RB_FP_GPIO        8'd4
`define RB_BAD_WORD       64'h0BADC0DE0BADC0DE

// Reset values
`define GPIO_DEFAULT_DDR  32'hFFFF_FFFF
`define GPIO_DEFAULT_IDLE 32'h0000_0000
`define SPI_SEN_IDLE      8'hFF

`endif

//--- run.sh
#!/usr/bin/env bash
# Build and run the db_control testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module db_control_tb \
  --Mdir obj_dir \
  -o db_control_tb_sim \
  -f all.f

status=0
./obj_dir/db_control_tb_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TB FAILED" sim.log || [ "$status" -ne 0 ]; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

//--- source/db_control.sv
// Daughterboard control top level
// Misc and sync registers, LED/front-panel/daughterboard GPIO banks,
// SPI master and the combinational readback multiplexer
`default_nettype none

`include "db_control_cfg.svh"

module db_control (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire                              set_stb,
  input  wire radio_regs_pkg::sr_addr_t    set_addr,
  input  wire radio_regs_pkg::sr_data_t    set_data,
  input  wire radio_regs_pkg::rb_addr_t    rb_addr,
  input  wire                              run_rx,
  input  wire                              run_tx,
  input  wire radio_regs_pkg::sr_data_t    misc_ins,
  input  wire frontend_io_pkg::gpio_word_t fp_gpio_in,
  input  wire frontend_io_pkg::gpio_word_t db_gpio_in,
  input  wire                              miso,
  output logic                             rb_stb,
  output radio_regs_pkg::rb_data_t         rb_data,
  output radio_regs_pkg::sr_data_t         misc_outs,
  output logic                             sync,
  output frontend_io_pkg::gpio_word_t      fp_gpio_out,
  output frontend_io_pkg::gpio_word_t      fp_gpio_ddr,
  output frontend_io_pkg::gpio_word_t      db_gpio_out,
  output frontend_io_pkg::gpio_word_t      db_gpio_ddr,
  output frontend_io_pkg::gpio_word_t      leds,
  output frontend_io_pkg::sen_t            sen,
  output logic                             sclk,
  output logic                             mosi
);

  import radio_regs_pkg::*;
  import frontend_io_pkg::*;

  gpio_word_t leds_rb;
  gpio_word_t fp_gpio_rb;
  gpio_word_t db_gpio_rb;
  sr_data_t   spi_readback;
  logic       spi_ready;

  setting_reg #(.MY_ADDR(`SR_MISC_OUTS), .data_t(sr_data_t)) u_sr_misc_outs (
    .clk(clk), .rst_n(rst_n),
    .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
    .out(misc_outs), .changed());

  // Sync pulse is the write strobe of this register
  setting_reg #(.MY_ADDR(`SR_SYNC), .data_t(logic)) u_sr_sync (
    .clk(clk), .rst_n(rst_n),
    .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
    .out(), .changed(sync));

  // LEDs are outputs only, their pins read back what is driven
  gpio_atr #(.BASE(`SR_LEDS)) u_leds_atr (
    .clk(clk), .rst_n(rst_n),
    .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
    .run_rx(run_rx), .run_tx(run_tx),
    .gpio_in(leds), .gpio_out(leds), .gpio_ddr(), .gpio_sw_rb(leds_rb));

  gpio_atr #(.BASE(`SR_FP_GPIO)) u_fp_gpio_atr (
    .clk(clk), .rst_n(rst_n),
    .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
    .run_rx(run_rx), .run_tx(run_tx),
    .gpio_in(fp_gpio_in), .gpio_out(fp_gpio_out), .gpio_ddr(fp_gpio_ddr),
    .gpio_sw_rb(fp_gpio_rb));

  gpio_atr #(.BASE(`SR_DB_GPIO)) u_db_gpio_atr (
    .clk(clk), .rst_n(rst_n),
    .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
    .run_rx(run_rx), .run_tx(run_tx),
    .gpio_in(db_gpio_in), .gpio_out(db_gpio_out), .gpio_ddr(db_gpio_ddr),
    .gpio_sw_rb(db_gpio_rb));

  simple_spi_core #(.BASE(`SR_SPI)) u_spi (
    .clk(clk), .rst_n(rst_n),
    .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
    .miso(miso), .readback(spi_readback), .ready(spi_ready),
    .sen(sen), .sclk(sclk), .mosi(mosi));

  // Readback select, SPI strobe follows ready so late reads still work
  always_comb begin
    rb_stb  = 1'b1;
    rb_data = `RB_BAD_WORD;
    case (rb_addr)
      `RB_MISC_IO: rb_data = rb_pack(misc_ins, misc_outs);
      `RB_SPI: begin
        rb_stb  = spi_ready;
        rb_data = rb_pack('0, spi_readback);
      end
      `RB_LEDS:    rb_data = rb_pack('0, leds_rb);
      `RB_DB_GPIO: rb_data = rb_pack('0, db_gpio_rb);
      `RB_FP_GPIO: rb_data = rb_pack('0, fp_gpio_rb);
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- source/frontend_io_pkg.sv
// GPIO word, ATR state, SPI chip select and SPI control types
// for the frontend and daughterboard pins
`default_nettype none

`include "db_control_cfg.svh"

package frontend_io_pkg;

  typedef logic [`GPIO_WIDTH-1:0] gpio_word_t;
  typedef logic [`SEN_WIDTH-1:0]  sen_t;

  // Encoded as {run_tx, run_rx}
  typedef enum logic [1:0] {
    ATR_IDLE        = 2'b00,
    ATR_RX_ONLY     = 2'b01,
    ATR_TX_ONLY     = 2'b10,
    ATR_FULL_DUPLEX = 2'b11
  } atr_state_e;

  // Low 16 bits of the SPI control word
  typedef struct packed {
    sen_t       sen_mask;
    logic [5:0] num_bits;
    logic       mosi_edge;
    logic       miso_edge;
  } spi_ctrl_t;

  function automatic atr_state_e atr_decode(input logic run_rx, input logic run_tx);
    return atr_state_e'({run_tx, run_rx});
  endfunction

endpackage

`default_nettype wire

//--- source/gpio_atr.sv
// Auto transmit/receive GPIO bank
// Four output words selected by run_rx/run_tx, a DDR word,
// and a registered software readback of the pins
`default_nettype none

`include "db_control_cfg.svh"

module gpio_atr #(
  parameter radio_regs_pkg::sr_addr_t BASE = 8'h00
) (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire                              set_stb,
  input  wire radio_regs_pkg::sr_addr_t    set_addr,
  input  wire radio_regs_pkg::sr_data_t    set_data,
  input  wire                              run_rx,
  input  wire                              run_tx,
  input  wire frontend_io_pkg::gpio_word_t gpio_in,
  output frontend_io_pkg::gpio_word_t      gpio_out,
  output frontend_io_pkg::gpio_word_t      gpio_ddr,
  output frontend_io_pkg::gpio_word_t      gpio_sw_rb
);

  import radio_regs_pkg::*;
  import frontend_io_pkg::*;

  // Word offsets from BASE
  localparam sr_addr_t ADDR_IDLE = BASE;
  localparam sr_addr_t ADDR_RX   = BASE + 8'd1;
  localparam sr_addr_t ADDR_TX   = BASE + 8'd2;
  localparam sr_addr_t ADDR_FDX  = BASE + 8'd3;
  localparam sr_addr_t ADDR_DDR  = BASE + 8'd4;

  gpio_word_t out_idle;
  gpio_word_t out_rx;
  gpio_word_t out_tx;
  gpio_word_t out_fdx;
  gpio_word_t out_sel;
  atr_state_e atr_state;

  // Settings writes, the DDR register drives the pin directions directly
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_idle <= `GPIO_DEFAULT_IDLE;
      out_rx   <= `GPIO_DEFAULT_IDLE;
      out_tx   <= `GPIO_DEFAULT_IDLE;
      out_fdx  <= `GPIO_DEFAULT_IDLE;
      gpio_ddr <= `GPIO_DEFAULT_DDR;
    end else if (set_stb) begin
      case (set_addr)
        ADDR_IDLE: out_idle <= gpio_word_t'(set_data);
        ADDR_RX:   out_rx   <= gpio_word_t'(set_data);
        ADDR_TX:   out_tx   <= gpio_word_t'(set_data);
        ADDR_FDX:  out_fdx  <= gpio_word_t'(set_data);
        ADDR_DDR:  gpio_ddr <= gpio_word_t'(set_data);
        default: ;
      endcase
    end
  end

  assign atr_state = atr_decode(run_rx, run_tx);

  // Pick the word for the current radio state
  always_comb begin
    out_sel = out_idle;
    case (atr_state)
      ATR_RX_ONLY:     out_sel = out_rx;
      ATR_TX_ONLY:     out_sel = out_tx;
      ATR_FULL_DUPLEX: out_sel = out_fdx;
      default:         out_sel = out_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gpio_out <= `GPIO_DEFAULT_IDLE;
    end else begin
      gpio_out <= out_sel;
    end
  end

  // Pin readback, one register stage
  always_ff @(posedge clk) begin
    gpio_sw_rb <= gpio_in;
  end

endmodule

`default_nettype wire

//--- source/radio_regs_pkg.sv
// Settings bus and readback types shared by the radio control blocks
`default_nettype none

`include "db_control_cfg.svh"

package radio_regs_pkg;

  // Settings bus, written by plain strobes
  typedef logic [`SR_AWIDTH-1:0] sr_addr_t;
  typedef logic [`SR_DWIDTH-1:0] sr_data_t;

  // Readback path, combinational select of one word
  typedef logic [`RB_AWIDTH-1:0] rb_addr_t;
  typedef logic [`RB_DWIDTH-1:0] rb_data_t;

  // Sizes used when packing words
  localparam int SR_DATA_BITS = $bits(sr_data_t);
  localparam int RB_DATA_BITS = $bits(rb_data_t);

  // Readback words are two settings words side by side
  function automatic rb_data_t rb_pack(input sr_data_t hi, input sr_data_t lo);
    return {hi, lo};
  endfunction

endpackage

`default_nettype wire

//--- source/setting_reg.sv
// One addressed settings register of a parameterized payload type
// changed is high for the cycle after each write
`default_nettype none

module setting_reg #(
  parameter radio_regs_pkg::sr_addr_t MY_ADDR = 8'h00,
  parameter type data_t = logic [31:0]
) (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           set_stb,
  input  wire radio_regs_pkg::sr_addr_t set_addr,
  input  wire radio_regs_pkg::sr_data_t set_data,
  output data_t                         out,
  output logic                          changed
);

  logic hit;

  // Only this register's address is decoded here
  assign hit = set_stb && (set_addr == MY_ADDR);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out     <= '0;
      changed <= 1'b0;
    end else begin
      changed <= hit;
      if (hit) begin
        // Payload comes from the low bits of the data word
        out <= data_t'(set_data[$bits(data_t)-1:0]);
      end
    end
  end

endmodule

`default_nettype wire

//--- source/simple_spi_core.sv
// SPI master programmed over the settings bus
// Divider, control and data words; a data write starts a transfer
// and ready rises again once num_bits bits have moved
`default_nettype none

`include "db_control_cfg.svh"

module simple_spi_core #(
  parameter radio_regs_pkg::sr_addr_t BASE = 8'h00
) (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           set_stb,
  input  wire radio_regs_pkg::sr_addr_t set_addr,
  input  wire radio_regs_pkg::sr_data_t set_data,
  input  wire                           miso,
  output radio_regs_pkg::sr_data_t      readback,
  output logic                          ready,
  output frontend_io_pkg::sen_t         sen,
  output logic                          sclk,
  output logic                          mosi
);

  import radio_regs_pkg::*;
  import frontend_io_pkg::*;

  localparam sr_addr_t ADDR_DIV  = BASE;
  localparam sr_addr_t ADDR_CTRL = BASE + 8'd1;
  localparam sr_addr_t ADDR_DATA = BASE + 8'd2;

  logic [`SPI_DIV_WIDTH-1:0] divider;
  logic [`SPI_DIV_WIDTH-1:0] clk_cnt;
  spi_ctrl_t                 ctrl;
  logic [5:0]                bit_cnt;
  sr_data_t                  tx_aligned;
  sr_data_t                  tx_shift;
  sr_data_t                  rx_shift;
  logic                      start;
  logic                      tick;
  logic                      rise;
  logic                      fall;
  logic                      drive;
  logic                      sample;

  // Writes to the data word while busy are dropped
  assign start = set_stb && (set_addr == ADDR_DATA) && ready;

  // Half period of sclk is divider+1 clocks
  assign tick   = !ready && (clk_cnt == divider);
  assign rise   = tick && !sclk;
  assign fall   = tick && sclk;
  assign drive  = ctrl.mosi_edge ? rise : fall;
  assign sample = ctrl.miso_edge ? rise : fall;

  // First bit to send is bit num_bits-1, moved up to the MSB
  assign tx_aligned = set_data << (6'd32 - ctrl.num_bits);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      divider <= '0;
      ctrl    <= '0;
    end else if (set_stb) begin
      if (set_addr == ADDR_DIV) begin
        divider <= set_data[`SPI_DIV_WIDTH-1:0];
      end
      if (set_addr == ADDR_CTRL) begin
        ctrl <= spi_ctrl_t'(set_data[15:0]);
      end
    end
  end

  // Transfer control, sclk idles low
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready   <= 1'b1;
      sen     <= `SPI_SEN_IDLE;
      sclk    <= 1'b0;
      mosi    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (start) begin
      ready   <= 1'b0;
      sen     <= ~ctrl.sen_mask;
      sclk    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= ctrl.num_bits;
      // Falling-edge launch puts the first bit out before the first rise
      mosi    <= ctrl.mosi_edge ? 1'b0 : tx_aligned[31];
    end else if (!ready) begin
      clk_cnt <= tick ? '0 : clk_cnt + 1'b1;
      if (tick) begin
        sclk <= ~sclk;
      end
      if (drive) begin
        mosi <= tx_shift[31];
      end
      // One bit is complete on each falling edge
      if (fall) begin
        bit_cnt <= bit_cnt - 6'd1;
        if (bit_cnt == 6'd1) begin
          ready <= 1'b1;
          sen   <= `SPI_SEN_IDLE;
          mosi  <= 1'b0;
        end
      end
    end
  end

  // Outgoing shift register
  always_ff @(posedge clk) begin
    if (start) begin
      tx_shift <= ctrl.mosi_edge ? tx_aligned : tx_aligned << 1;
    end else if (drive) begin
      tx_shift <= tx_shift << 1;
    end
  end

  // Received bits, right-aligned
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_shift <= '0;
    end else if (start) begin
      rx_shift <= '0;
    end else if (sample) begin
      rx_shift <= {rx_shift[30:0], miso};
    end
  end

  assign readback = rx_shift;

endmodule

`default_nettype wire

//--- tests/db_control_assert.sv
// Concurrent checks on the sync pulse and the idle SPI bus
`default_nettype none

`include "db_control_cfg.svh"

module db_control_assert (
  input wire                        clk,
  input wire                        rst_n,
  input wire                        sync,
  input wire                        ready,
  input wire frontend_io_pkg::sen_t sen,
  input wire                        sclk
);

  // Sync is a single-cycle pulse
  sync_single: assert property (@(posedge clk) disable iff (!rst_n) sync |=> !sync)
    else $error("sync stayed high for two cycles");

  // No chip select while the core is idle
  sen_idle: assert property (@(posedge clk) disable iff (!rst_n)
    ready |-> (sen == `SPI_SEN_IDLE))
    else $error("chip select active while SPI ready");

  sclk_still: assert property (@(posedge clk) disable iff (!rst_n)
    (ready && $past(ready)) |-> $stable(sclk))
    else $error("sclk moved while SPI ready");

endmodule

`default_nettype wire

//--- tests/db_control_tb.sv
// Testbench for the daughterboard control block
// Register model, reference function, compare process and LFSR stimulus
`default_nettype none

`include "db_control_cfg.svh"

module db_control_tb;

  import radio_regs_pkg::*;
  import frontend_io_pkg::*;

  // Compare kinds, 1 to 3 are the LED, front-panel and daughterboard banks
  localparam int K_RB   = 0;
  localparam int K_SYNC = 4;
  localparam int K_SEN  = 5;
  localparam int K_PINS = 6;
  localparam int K_MISC = 7;
  localparam int SPI_TIMEOUT = 2000;
  localparam sr_addr_t BANK_BASE [3] = '{`SR_LEDS, `SR_FP_GPIO, `SR_DB_GPIO};

  logic       clk;
  logic       rst_n;
  logic       set_stb;
  sr_addr_t   set_addr;
  sr_data_t   set_data;
  rb_addr_t   rb_addr;
  logic       run_rx;
  logic       run_tx;
  sr_data_t   misc_ins;
  gpio_word_t fp_gpio_in;
  gpio_word_t db_gpio_in;
  logic       miso;
  logic       rb_stb;
  rb_data_t   rb_data;
  sr_data_t   misc_outs;
  logic       sync;
  gpio_word_t fp_gpio_out;
  gpio_word_t fp_gpio_ddr;
  gpio_word_t db_gpio_out;
  gpio_word_t db_gpio_ddr;
  gpio_word_t leds;
  sen_t       sen;
  logic       sclk;
  logic       mosi;

  // Register model kept by the stimulus
  sr_data_t    misc_model;
  gpio_word_t  atr_model [3][4];
  gpio_word_t  ddr_model [3];
  sr_data_t    spi_rb_model;
  logic        spi_busy_model;
  logic [31:0] lfsr;

  // One pending compare request
  int          req_cnt = 0;
  int          ack_cnt = 0;
  int          chk_kind;
  string       chk_name;
  logic [64:0] chk_exp;

  tb_clk_gen u_clk (.clk(clk));

  db_control u_dut (.*);

  bind db_control db_control_assert u_assert (
    .clk(clk), .rst_n(rst_n), .sync(sync), .ready(spi_ready), .sen(sen), .sclk(sclk));

  // SPI data comes straight back in
  assign miso = mosi;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic void model_write(input sr_addr_t addr, input sr_data_t data);
    if (addr == `SR_MISC_OUTS) begin
      misc_model = data;
    end
    for (int b = 0; b < 3; b++) begin
      if (addr >= BANK_BASE[b] && addr < BANK_BASE[b] + 8'd4) begin
        atr_model[b][2'(addr - BANK_BASE[b])] = data;
      end else if (addr == BANK_BASE[b] + 8'd4) begin
        ddr_model[b] = data;
      end
    end
  endfunction

  // Word index is {run_tx, run_rx}: idle, rx only, tx only, full duplex
  function automatic gpio_word_t atr_expect(input int b);
    return atr_model[b][{run_tx, run_rx}];
  endfunction

  // Expected value for a compare kind, readback is {strobe, word}
  function automatic logic [64:0] reference(input int kind);
    case (kind)
      1: return {33'b0, atr_expect(0)};
      2: return {1'b0, ddr_model[1], atr_expect(1)};
      3: return {1'b0, ddr_model[2], atr_expect(2)};
      K_MISC: return {33'b0, misc_model};
      K_SYNC, K_SEN, K_PINS: return chk_exp;
      default: begin
        case (rb_addr)
          `RB_MISC_IO: return {1'b1, misc_ins, misc_model};
          `RB_SPI:     return {!spi_busy_model, 32'h0, spi_rb_model};
          `RB_LEDS:    return {1'b1, 32'h0, atr_expect(0)};
          `RB_DB_GPIO: return {1'b1, 32'h0, db_gpio_in};
          `RB_FP_GPIO: return {1'b1, 32'h0, fp_gpio_in};
          default:     return {1'b1, `RB_BAD_WORD};
        endcase
      end
    endcase
  endfunction

  function automatic logic [64:0] dut_value(input int kind);
    case (kind)
      1:       return {33'b0, leds};
      2:       return {1'b0, fp_gpio_ddr, fp_gpio_out};
      3:       return {1'b0, db_gpio_ddr, db_gpio_out};
      K_MISC:  return {33'b0, misc_outs};
      K_SYNC:  return {64'b0, sync};
      K_SEN:   return {57'b0, sen};
      K_PINS:  return {63'b0, sclk, mosi};
      default: return {rb_stb, rb_data};
    endcase
  endfunction

  task automatic check(input string name, input logic [64:0] exp, input logic [64:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      $display("TB FAILED");
      $fatal(1, "Value mismatch in %s", name);
    end
  endtask

  // Outputs are sampled on the rising edge, settled since the falling edge
  always @(posedge clk) begin
    if (req_cnt != ack_cnt) begin
      check(chk_name, reference(chk_kind), dut_value(chk_kind));
      ack_cnt = req_cnt;
    end
  end

  // Queue one compare and move on to the next falling edge
  task automatic expect_at(input string name, input int kind, input logic [64:0] exp);
    chk_name = name;
    chk_kind = kind;
    chk_exp  = exp;
    req_cnt++;
    @(negedge clk);
  endtask

  task automatic bus_write(input sr_addr_t addr, input sr_data_t data);
    set_stb  = 1'b1;
    set_addr = addr;
    set_data = data;
    @(negedge clk);
    set_stb  = 1'b0;
    model_write(addr, data);
  endtask

  task automatic spi_transfer(input sr_data_t data, input int nb, input int dv,
                              input sen_t mask, input logic me);
    spi_ctrl_t ctrl;
    sr_data_t  keep;
    int        busy;
    ctrl.sen_mask  = mask;
    ctrl.num_bits  = 6'(nb);
    ctrl.mosi_edge = me;
    ctrl.miso_edge = !me;
    keep = (nb == 32) ? 32'hFFFF_FFFF : (32'h1 << nb) - 32'h1;
    rb_addr = `RB_SPI;
    bus_write(`SR_SPI, sr_data_t'(dv));
    bus_write(`SR_SPI + 8'd1, {16'h0, ctrl});
    bus_write(`SR_SPI + 8'd2, data);
    spi_busy_model = 1'b1;
    spi_rb_model   = '0;
    expect_at("spi_start", K_RB, 0);
    busy = 1;
    while (rb_stb !== 1'b1) begin
      if (busy > SPI_TIMEOUT) begin
        $display("Timeout: SPI ready did not rise after %0d cycles", busy);
        $display("TB FAILED");
        $fatal(1, "SPI transfer timed out");
      end
      expect_at("spi_sen_busy", K_SEN, {57'b0, ~mask});
      busy++;
    end
    spi_busy_model = 1'b0;
    spi_rb_model   = data & keep;
    // Each bit takes two sclk half periods of divider+1 clocks
    check("spi_latency", 65'(2 * nb * (dv + 1)), 65'(busy));
    expect_at("spi_readback", K_RB, 0);
    expect_at("spi_sen_idle", K_SEN, {57'b0, `SPI_SEN_IDLE});
    expect_at("spi_pins_idle", K_PINS, 0);
  endtask

  initial begin
    int b;
    int s;
    int i;
    lfsr           = 32'h54fb;
    rst_n          = 1'b0;
    set_stb        = 1'b0;
    set_addr       = '0;
    set_data       = '0;
    rb_addr        = '0;
    run_rx         = 1'b0;
    run_tx         = 1'b0;
    misc_ins       = '0;
    fp_gpio_in     = '0;
    db_gpio_in     = '0;
    misc_model     = '0;
    spi_rb_model   = '0;
    spi_busy_model = 1'b0;
    for (b = 0; b < 3; b++) begin
      ddr_model[b] = `GPIO_DEFAULT_DDR;
      for (s = 0; s < 4; s++) begin
        atr_model[b][s] = `GPIO_DEFAULT_IDLE;
      end
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Reset state
    rb_addr = `RB_SPI;
    expect_at("reset_spi_rb", K_RB, 0);
    expect_at("reset_sync", K_SYNC, 0);
    expect_at("reset_sen", K_SEN, {57'b0, `SPI_SEN_IDLE});
    expect_at("reset_pins", K_PINS, 0);
    expect_at("reset_misc", K_MISC, 0);
    for (b = 1; b <= 3; b++) begin
      expect_at($sformatf("reset_bank%0d", b), b, 0);
    end

    // Misc register, unknown readback code and sync pulse
    for (i = 0; i < 8; i++) begin
      bus_write(`SR_MISC_OUTS, rand_bits(32));
      expect_at("misc_outs", K_MISC, 0);
      misc_ins = rand_bits(32);
      rb_addr  = `RB_MISC_IO;
      expect_at("misc_readback", K_RB, 0);
    end
    rb_addr = 8'd5 + 8'(rand_bits(7));
    expect_at("bad_word", K_RB, 0);
    set_stb  = 1'b1;
    set_addr = `SR_SYNC;
    set_data = rand_bits(32);
    expect_at("sync_early", K_SYNC, 0);
    set_stb = 1'b0;
    expect_at("sync_pulse", K_SYNC, 1);
    expect_at("sync_single", K_SYNC, 0);

    // ATR words and DDR in all three banks, then every radio state
    for (b = 0; b < 3; b++) begin
      for (s = 0; s < 5; s++) begin
        bus_write(BANK_BASE[b] + 8'(s), rand_bits(32));
      end
    end
    for (s = 0; s < 4; s++) begin
      run_rx = s[0];
      run_tx = s[1];
      @(negedge clk);
      for (b = 1; b <= 3; b++) begin
        expect_at($sformatf("atr_bank%0d_state%0d", b, s), b, 0);
      end
    end

    // Pin readback
    for (i = 0; i < 4; i++) begin
      fp_gpio_in = rand_bits(32);
      db_gpio_in = rand_bits(32);
      @(negedge clk);
      rb_addr = `RB_FP_GPIO;
      expect_at("fp_readback", K_RB, 0);
      rb_addr = `RB_DB_GPIO;
      expect_at("db_readback", K_RB, 0);
      rb_addr = `RB_LEDS;
      expect_at("leds_readback", K_RB, 0);
    end

    // SPI loopback transfers
    for (i = 0; i < 8; i++) begin
      sr_data_t data;
      int       nb;
      int       dv;
      sen_t     mask;
      logic     me;
      data = rand_bits(32);
      nb   = int'(rand_bits(5)) + 1;
      dv   = int'(rand_bits(3));
      mask = sen_t'(rand_bits(8));
      me   = rand_bits(1) != 0;
      spi_transfer(data, nb, dv, mask, me);
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
// Free-running testbench clock, 40 time units per period
`default_nettype none

module tb_clk_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

endmodule

`default_nettype wire
